/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes of the supported subset
  localparam logic [6:0] op_lui     = 7'b01_101_11;
  localparam logic [6:0] op_reg_imm = 7'b00_100_11;
  localparam logic [6:0] op_reg_reg = 7'b01_100_11;
  localparam logic [6:0] op_branch  = 7'b11_000_11;
  localparam logic [6:0] op_environ = 7'b11_100_11;

  // funct7 for base ops, and for sub / sra / srai
  localparam logic [6:0] funct7_base = 7'b000_0000;
  localparam logic [6:0] funct7_alt  = 7'b010_0000;

  // instruction word views, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // branch offset is scattered over the rd and funct7 slots
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
  } rv_insn_u;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // values match funct3 of the branch group
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_op_e;

  typedef enum logic [2:0] {
    cls_alu, cls_branch, cls_ecall, cls_illegal
  } insn_class_e;

  typedef struct packed {
    insn_class_e insn_class;
    alu_op_e     alu_op;
    branch_op_e  branch_op;
    logic        use_imm;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic        rd_we;
    word_t       imm;
  } decoded_t;

  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } reg_write_t;

endpackage

`default_nettype wire

/* src/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  rv_pkg::rv_insn_u insn,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  word_t imm_i;
  word_t imm_b;
  word_t imm_u;
  logic  legal;

  // sign-extended immediates, one per format view
  assign imm_i = {{(xlen-12){insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
  assign imm_b = {{(xlen-12){insn.b_fmt.imm_12}}, insn.b_fmt.imm_11,
                  insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {insn.u_fmt.imm, 12'b0};

  always_comb begin
    dec            = '0;
    dec.insn_class = cls_illegal;
    dec.alu_op     = alu_add;
    dec.branch_op  = br_beq;
    dec.rs1        = insn.r_fmt.rs1;
    dec.rs2        = insn.r_fmt.rs2;
    dec.rd         = insn.r_fmt.rd;
    legal          = 1'b0;

    case (insn.r_fmt.opcode)
      op_lui: begin
        // rd gets the immediate straight through the alu
        dec.insn_class = cls_alu;
        dec.alu_op     = alu_pass_b;
        dec.use_imm    = 1'b1;
        dec.imm        = imm_u;
        legal          = 1'b1;
      end

      op_reg_imm: begin
        dec.insn_class = cls_alu;
        dec.use_imm    = 1'b1;
        dec.imm        = imm_i;
        legal          = 1'b1;
        case (insn.i_fmt.funct3)
          3'b000: dec.alu_op = alu_add;
          3'b010: dec.alu_op = alu_slt;
          3'b011: dec.alu_op = alu_sltu;
          3'b100: dec.alu_op = alu_xor;
          3'b110: dec.alu_op = alu_or;
          3'b111: dec.alu_op = alu_and;
          3'b001: begin
            dec.alu_op = alu_sll;
            legal      = (insn.r_fmt.funct7 == funct7_base);
          end
          default: begin
            // shift right, funct7 picks logical or arithmetic
            if (insn.r_fmt.funct7 == funct7_alt) begin
              dec.alu_op = alu_sra;
            end else begin
              dec.alu_op = alu_srl;
            end
            legal = (insn.r_fmt.funct7 == funct7_base) ||
                    (insn.r_fmt.funct7 == funct7_alt);
          end
        endcase
      end

      op_reg_reg: begin
        dec.insn_class = cls_alu;
        legal          = 1'b1;
        case ({insn.r_fmt.funct7, insn.r_fmt.funct3})
          {funct7_base, 3'b000}: dec.alu_op = alu_add;
          {funct7_alt,  3'b000}: dec.alu_op = alu_sub;
          {funct7_base, 3'b001}: dec.alu_op = alu_sll;
          {funct7_base, 3'b010}: dec.alu_op = alu_slt;
          {funct7_base, 3'b011}: dec.alu_op = alu_sltu;
          {funct7_base, 3'b100}: dec.alu_op = alu_xor;
          {funct7_base, 3'b101}: dec.alu_op = alu_srl;
          {funct7_alt,  3'b101}: dec.alu_op = alu_sra;
          {funct7_base, 3'b110}: dec.alu_op = alu_or;
          {funct7_base, 3'b111}: dec.alu_op = alu_and;
          default:               legal      = 1'b0;
        endcase
      end

      op_branch: begin
        dec.insn_class = cls_branch;
        dec.imm        = imm_b;
        dec.branch_op  = branch_op_e'(insn.b_fmt.funct3);
        // funct3 010 and 011 are holes in the branch group
        legal          = (insn.b_fmt.funct3[2:1] != 2'b01);
      end

      op_environ: begin
        dec.insn_class = cls_ecall;
        legal          = (insn[31:7] == '0);
      end

      default: legal = 1'b0;
    endcase

    if (!legal) begin
      dec.insn_class = cls_illegal;
    end
    dec.rd_we = (dec.insn_class == cls_alu);
  end

endmodule

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic               clk,
  input  logic               rst,
  input  rv_pkg::reg_addr_t  rs1,
  input  rv_pkg::reg_addr_t  rs2,
  output rv_pkg::word_t      rs1_data,
  output rv_pkg::word_t      rs2_data,
  input  rv_pkg::reg_write_t wr
);
  import rv_pkg::*;

  word_t regs [num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we && (wr.addr != '0)) begin
      regs[wr.addr] <= wr.data;
    end
  end

  // x0 reads as zero whatever the storage holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // a write aimed at x0 leaves its storage clear
  a_x0_untouched: assert property (
    @(posedge clk) disable iff (rst)
    (wr.we && (wr.addr == '0)) |=> (regs[0] == '0)
  );

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    alu_result,
  output logic             branch_taken
);
  import rv_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       br_eq;
  logic       br_lt;
  logic       br_ltu;
  logic       br_cond;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  // only the low five bits shift in rv32
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(rs1_data) < $signed(op_b);
  assign lt_unsigned = rs1_data < op_b;

  always_comb begin
    case (dec.alu_op)
      alu_add:    alu_result = rs1_data + op_b;
      alu_sub:    alu_result = rs1_data - op_b;
      alu_sll:    alu_result = rs1_data << shamt;
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    alu_result = rs1_data ^ op_b;
      alu_srl:    alu_result = rs1_data >> shamt;
      alu_sra:    alu_result = $signed(rs1_data) >>> shamt;
      alu_or:     alu_result = rs1_data | op_b;
      alu_and:    alu_result = rs1_data & op_b;
      alu_pass_b: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // branch compare always uses both registers
  assign br_eq  = (rs1_data == rs2_data);
  assign br_lt  = $signed(rs1_data) < $signed(rs2_data);
  assign br_ltu = rs1_data < rs2_data;

  always_comb begin
    case (dec.branch_op)
      br_beq:  br_cond = br_eq;
      br_bne:  br_cond = !br_eq;
      br_blt:  br_cond = br_lt;
      br_bge:  br_cond = !br_lt;
      br_bltu: br_cond = br_ltu;
      br_bgeu: br_cond = !br_ltu;
      default: br_cond = 1'b0;
    endcase
  end

  assign branch_taken = (dec.insn_class == cls_branch) && br_cond;

endmodule

`default_nettype wire

/* src/rv_result.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_result (
  input  logic               clk,
  input  logic               rst,
  input  rv_pkg::decoded_t   dec,
  input  rv_pkg::word_t      alu_result,
  input  logic               branch_taken,
  output rv_pkg::word_t      pc,
  output logic               halt,
  output rv_pkg::reg_write_t wr,
  output logic               illegal
);
  import rv_pkg::*;

  word_t next_pc;

  // taken branch jumps by the B offset, all else steps one word
  assign next_pc = branch_taken ? (pc + dec.imm) : (pc + word_t'(4));

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= '0;
      halt <= 1'b0;
    end else if (!halt) begin
      pc <= next_pc;
      if (dec.insn_class == cls_ecall) begin
        halt <= 1'b1;
      end
    end
  end

  // retire port and regfile write share this struct
  always_comb begin
    wr.we   = dec.rd_we && !halt;
    wr.addr = dec.rd;
    wr.data = alu_result;
  end

  assign illegal = (dec.insn_class == cls_illegal) && !halt;

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  );

  // once halted the core sits on the same pc
  a_pc_frozen: assert property (
    @(posedge clk) disable iff (rst)
    halt |=> $stable(pc)
  );

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic               clk,
  input  logic               rst,
  output rv_pkg::word_t      pc,
  input  rv_pkg::rv_insn_u   insn,
  output rv_pkg::reg_write_t retire,
  output logic               illegal,
  output logic               halt
);
  import rv_pkg::*;

  decoded_t dec;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_result;
  logic     branch_taken;

  rv_decoder u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (retire)
  );

  rv_execute u_execute (
    .dec          (dec),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  // write of this cycle doubles as the retire port
  rv_result u_result (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .pc           (pc),
    .halt         (halt),
    .wr           (retire),
    .illegal      (illegal)
  );

endmodule

`default_nettype wire

/* tb/rv_model.svh */
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// architectural register state as the model sees it
word_t model_regs [32];

// funct3 picks the operation, alt is the sub / sra variant
function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
  case (f3)
    3'b000: begin
      if (alt) return a - b;
      return a + b;
    end
    3'b001: return a << b[4:0];
    3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: return (a < b) ? 32'd1 : 32'd0;
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic model_branch(input logic [2:0] f3, input word_t a, input word_t b);
  case (f3)
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    3'b110: return a < b;
    default: return a >= b;
  endcase
endfunction

// one instruction on the model state, prediction of the core's outputs
function automatic void model_step(input logic [31:0] w, input word_t pc_now,
                                   output reg_write_t exp_wr, output logic exp_ill,
                                   output logic exp_ecall, output word_t exp_next);
  logic [6:0] opcode;
  logic [6:0] f7;
  logic [2:0] f3;
  logic [4:0] rd;
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      imm_b;
  logic       legal;
  logic       taken;
  opcode = w[6:0];
  rd     = w[11:7];
  f3     = w[14:12];
  f7     = w[31:25];
  a      = model_regs[w[19:15]];
  b      = model_regs[w[24:20]];
  imm_i  = {{20{w[31]}}, w[31:20]};
  imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  exp_wr = '0;
  exp_wr.addr = rd;
  legal     = 1'b0;
  taken     = 1'b0;
  exp_ecall = 1'b0;
  case (opcode)
    7'h37: begin
      legal       = 1'b1;
      exp_wr.we   = 1'b1;
      exp_wr.data = {w[31:12], 12'h000};
    end
    7'h13: begin
      if (f3 == 3'b001) begin
        legal = (f7 == 7'h00);
      end else if (f3 == 3'b101) begin
        legal = (f7 == 7'h00) || (f7 == 7'h20);
      end else begin
        legal = 1'b1;
      end
      exp_wr.we   = legal;
      exp_wr.data = model_alu(f3, (f3 == 3'b101) && f7[5], a, imm_i);
    end
    7'h33: begin
      legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
      exp_wr.we   = legal;
      exp_wr.data = model_alu(f3, f7[5], a, b);
    end
    7'h63: begin
      legal = (f3 != 3'b010) && (f3 != 3'b011);
      taken = legal && model_branch(f3, a, b);
    end
    7'h73: begin
      legal     = (w[31:7] == '0);
      exp_ecall = legal;
    end
    default: legal = 1'b0;
  endcase
  exp_ill  = !legal;
  exp_next = taken ? (pc_now + imm_b) : (pc_now + 32'd4);
  if (exp_wr.we && (rd != 5'd0)) begin
    model_regs[rd] = exp_wr.data;
  end
endfunction

`endif

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  logic       clk = 1'b0;
  logic       rst;
  word_t      pc;
  rv_insn_u   insn;
  reg_write_t retire;
  logic       illegal;
  logic       halt;

  logic [31:0] mem [64];
  logic [31:0] lfsr_state;
  int          err_write;
  int          err_pc;
  int          err_flag;
  int          err_timeout;
  logic        timed_out;

  `include "rv_model.svh"

  rv_core dut (
    .clk     (clk),
    .rst     (rst),
    .pc      (pc),
    .insn    (insn),
    .retire  (retire),
    .illegal (illegal),
    .halt    (halt)
  );

  always #5 clk = ~clk;

  // taps x^32 + x^22 + x^2 + x + 1 and one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] gen_insn(input int idx);
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic [2:0]  pick;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [6:0]  f7;
    logic [24:0] body;
    logic [12:0] off;
    int          steps;
    kind = 4'(take_bits(4));
    f3   = 3'(take_bits(3));
    rd   = 5'(take_bits(5));
    rs1  = 5'(take_bits(5));
    rs2  = 5'(take_bits(5));
    case (kind)
      4'd0: begin
        // dropped or unused encodings in 1 of 16 slots
        pick = 3'(take_bits(3));
        body = 25'(take_bits(25));
        case (pick)
          3'd0: return {body, 7'b0000011};
          3'd1: return {body, 7'b0100011};
          3'd2: return {body, 7'b1101111};
          3'd3: return {body, 7'b1100111};
          3'd4: return {body, 7'b0010111};
          3'd5: return {7'b000_0001, rs2, rs1, f3, rd, op_reg_reg};
          3'd6: return {body[24:1], 1'b1, op_environ};
          default: return {body[24:8], 2'b01, body[0], body[4:0], op_branch};
        endcase
      end
      4'd1, 4'd2: return {20'(take_bits(20)), rd, op_lui};
      4'd3, 4'd4, 4'd5, 4'd6, 4'd14, 4'd15: begin
        if (f3 == 3'b001) begin
          return {funct7_base, 5'(take_bits(5)), rs1, f3, rd, op_reg_imm};
        end
        if (f3 == 3'b101) begin
          f7 = (take_bits(1) != 0) ? funct7_alt : funct7_base;
          return {f7, 5'(take_bits(5)), rs1, f3, rd, op_reg_imm};
        end
        return {12'(take_bits(12)), rs1, f3, rd, op_reg_imm};
      end
      4'd7, 4'd8, 4'd9, 4'd10: begin
        f7 = funct7_base;
        if (((f3 == 3'b000) || (f3 == 3'b101)) && (take_bits(1) != 0)) begin
          f7 = funct7_alt;
        end
        return {f7, rs2, rs1, f3, rd, op_reg_reg};
      end
      default: begin
        // skip the two funct3 holes and keep the target inside the program
        if (f3[2:1] == 2'b01) begin
          f3 = f3 ^ 3'b110;
        end
        steps = 1 + int'(take_bits(2));
        if (idx + steps > 63) begin
          steps = 63 - idx;
        end
        off = 13'(steps * 4);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
      end
    endcase
  endfunction

  // past the last word the core only sees ecall
  function automatic logic [31:0] fetch_word(input word_t addr);
    if (addr < 32'd256) return mem[addr[7:2]];
    return 32'h0000_0073;
  endfunction

  task automatic check_write(input string name, input reg_write_t exp, input reg_write_t act);
    logic bad;
    bad = (act.we !== exp.we);
    if (exp.we) begin
      bad = bad || (act.addr !== exp.addr) || (act.data !== exp.data);
    end
    if (bad) begin
      err_write++;
      $display("CHECK FAILED %s: expected we=%0b x%0d=%h, actual we=%0b x%0d=%h",
               name, exp.we, exp.addr, exp.data, act.we, act.addr, act.data);
    end
  endtask

  task automatic check_pc(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      err_pc++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_flag++;
      $display("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic run_program(input int p);
    word_t      exp_pc;
    word_t      exp_next;
    reg_write_t exp_wr;
    reg_write_t idle_wr;
    logic       exp_ill;
    logic       exp_ecall;
    int         cycles;
    for (int i = 0; i < 63; i++) begin
      mem[i] = gen_insn(i);
    end
    mem[63] = 32'h0000_0073;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    idle_wr = '0;

    rst  = 1'b1;
    insn = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check_pc($sformatf("reset pc, program %0d", p), 32'd0, pc);
    check_flag("reset halt", 1'b0, halt);
    check_flag("reset retire.we", 1'b0, retire.we);

    exp_pc = '0;
    cycles = 0;
    while (!halt && (cycles < 200)) begin
      check_pc($sformatf("pc, program %0d", p), exp_pc, pc);
      insn = fetch_word(exp_pc);
      @(negedge clk);
      model_step(insn, exp_pc, exp_wr, exp_ill, exp_ecall, exp_next);
      check_write($sformatf("retire at pc %h", exp_pc), exp_wr, retire);
      check_flag($sformatf("illegal at pc %h", exp_pc), exp_ill, illegal);
      @(posedge clk);
      #1;
      check_flag($sformatf("halt after pc %h", exp_pc), exp_ecall, halt);
      exp_pc = exp_next;
      cycles++;
    end

    if (!halt) begin
      err_timeout++;
      timed_out = 1'b1;
      $display("timeout: program %0d did not halt within 200 cycles", p);
    end else begin
      check_pc("pc at halt", exp_pc, pc);
      for (int k = 0; k < 10; k++) begin
        // alternate a LUI that would write with a custom opcode that is illegal
        if ((k % 2) == 0) begin
          insn = {25'(take_bits(25)), op_lui};
        end else begin
          insn = {25'(take_bits(25)), 7'b0001011};
        end
        @(negedge clk);
        check_write("retire while halted", idle_wr, retire);
        check_flag("illegal while halted", 1'b0, illegal);
        @(posedge clk);
        #1;
        check_pc("pc while halted", exp_pc, pc);
        check_flag("halt held", 1'b1, halt);
      end
    end
  endtask

  initial begin
    rst         = 1'b1;
    insn        = '0;
    lfsr_state  = 32'd29604;
    err_write   = 0;
    err_pc      = 0;
    err_flag    = 0;
    err_timeout = 0;
    timed_out   = 1'b0;

    for (int p = 0; (p < 3) && !timed_out; p++) begin
      run_program(p);
    end

    $display("errors: write %0d, pc %0d, flag %0d, timeout %0d",
             err_write, err_pc, err_flag, err_timeout);
    if ((err_write + err_pc + err_flag + err_timeout) == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tb
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
tb/tb_rv_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_rv_core -f vlog.f

out=$(./obj_dir/Vtb_rv_core) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q -F '*** TEST PASSED ***'; then
  exit 0
else
  exit 1
fi
